//--- include/rv32i_macros.svh
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// architectural register count
`define RV_NUM_REGS 32

`define RV_XLEN     32  // data and instruction width

// width of the post-reset register sweep counter
`define RV_CLR_W    5

`endif

//--- design/rv32i_pkg.sv
`include "rv32i_macros.svh"

package rv32i_pkg;

    typedef logic [`RV_XLEN-1:0]             word_t;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_sel_t;

    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011,
        op_b_csr   = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    // branch and slt compares travel in the alu_op field
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic [1:0] {
        st_clear,
        st_run,
        st_bubble
    } issue_state_t;

    typedef struct packed {
        logic regf_we;
        logic mem_read;
        logic mem_write;
        logic branch;
        logic jal;
        logic jalr;
        logic alu_src;  // 1 selects imm as second operand
    } ctrl_t;

    typedef struct packed {
        word_t    pc;
        reg_sel_t rs1_s;
        reg_sel_t rs2_s;
        reg_sel_t rd_s;
        word_t    rs1_v;
        word_t    rs2_v;
        word_t    imm;
        alu_op_t  alu_op;
        logic     alu_or_cmp;  // 1 alu, 0 compare
        ctrl_t    ctrl;
    } id_ex_t;

endpackage

//--- design/wb_if.sv
`timescale 1ns/1ps

interface wb_if;

    logic                we;
    logic                valid;
    rv32i_pkg::reg_sel_t rd_s;
    rv32i_pkg::word_t    rd_v;

    // write-back producer side
    modport source (
        output we,
        output valid,
        output rd_s,
        output rd_v
    );

    modport regf (
        input we,
        input valid,
        input rd_s,
        input rd_v
    );

endinterface

//--- design/pipeline_regfile.sv
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module pipeline_regfile (
    input  logic                clk,
    wb_if.regf                  wb,
    input  rv32i_pkg::reg_sel_t rs1_s,
    input  rv32i_pkg::reg_sel_t rs2_s,
    output rv32i_pkg::word_t    rs1_v,
    output rv32i_pkg::word_t    rs2_v
);

    rv32i_pkg::word_t regs [`RV_NUM_REGS];
    logic             wr;

    assign wr = wb.we && wb.valid && (wb.rd_s != '0);  // x0 never stored

    always_ff @(posedge clk) begin
        if (wr) begin
            regs[wb.rd_s] <= wb.rd_v;
        end
    end

    // write in flight wins over the stored copy
    function automatic rv32i_pkg::word_t read_port(input rv32i_pkg::reg_sel_t sel);
        if (sel == '0)
            return '0;
        else if (wr && (wb.rd_s == sel))
            return wb.rd_v;
        else
            return regs[sel];
    endfunction

    assign rs1_v = read_port(rs1_s);
    assign rs2_v = read_port(rs2_s);

endmodule

//--- design/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                clk,
    input  logic                reset,
    input  rv32i_pkg::word_t    inst,
    input  rv32i_pkg::word_t    pc,
    wb_if.regf                  wb,
    output rv32i_pkg::id_ex_t   id_ex_next,
    output rv32i_pkg::reg_sel_t rs1_s,
    output rv32i_pkg::reg_sel_t rs2_s
);

    rv32i_pkg::opcode_t  opcode;
    logic [2:0]          funct3;
    rv32i_pkg::reg_sel_t rd_s;
    rv32i_pkg::word_t    i_imm, s_imm, b_imm, u_imm, imm;
    rv32i_pkg::word_t    rs1_v, rs2_v;
    rv32i_pkg::ctrl_t    ctrl;
    rv32i_pkg::alu_op_t  alu_op;
    logic                alu_or_cmp;

    wb_if rf_wb ();

    assign opcode = rv32i_pkg::opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];

    // hold off writes until the first reset edge has settled the FSM
    assign rf_wb.we    = wb.we && !reset;
    assign rf_wb.valid = wb.valid;
    assign rf_wb.rd_s  = wb.rd_s;
    assign rf_wb.rd_v  = wb.rd_v;

    always_comb begin
        rs1_s = inst[19:15];
        rs2_s = inst[24:20];
        case (opcode)
            rv32i_pkg::op_b_lui, rv32i_pkg::op_b_auipc, rv32i_pkg::op_b_jal: begin
                rs1_s = '0;
                rs2_s = '0;
            end
            rv32i_pkg::op_b_jalr, rv32i_pkg::op_b_load, rv32i_pkg::op_b_imm: begin
                rs2_s = '0;
            end
            default: ;  // br, store, reg, csr read both
        endcase
    end

    assign rd_s = (opcode == rv32i_pkg::op_b_store || opcode == rv32i_pkg::op_b_br)
                  ? '0 : inst[11:7];

    always_comb begin
        s_imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
        b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        u_imm = {inst[31:12], 12'h000};
        if (opcode == rv32i_pkg::op_b_imm && funct3 == 3'b101)
            i_imm = {{27{inst[31]}}, inst[24:20]};  // shamt only
        else
            i_imm = {{21{inst[31]}}, inst[30:20]};

        case (opcode)
            rv32i_pkg::op_b_lui, rv32i_pkg::op_b_auipc: imm = u_imm;
            rv32i_pkg::op_b_jal, rv32i_pkg::op_b_jalr:  imm = 32'd4;  // link value offset
            rv32i_pkg::op_b_br:                         imm = b_imm;
            rv32i_pkg::op_b_store:                      imm = s_imm;
            rv32i_pkg::op_b_load, rv32i_pkg::op_b_imm,
            rv32i_pkg::op_b_csr:                        imm = i_imm;
            default:                                    imm = '0;
        endcase
    end

    always_comb begin
        ctrl       = '0;
        alu_op     = rv32i_pkg::alu_add;
        alu_or_cmp = 1'b1;
        case (opcode)
            rv32i_pkg::op_b_lui, rv32i_pkg::op_b_auipc: begin
                ctrl.regf_we = 1'b1;
                ctrl.alu_src = 1'b1;
            end
            rv32i_pkg::op_b_jal: begin
                ctrl.regf_we = 1'b1;
                ctrl.jal     = 1'b1;
                ctrl.alu_src = 1'b1;
            end
            rv32i_pkg::op_b_jalr: begin
                ctrl.regf_we = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.alu_src = 1'b1;
            end
            rv32i_pkg::op_b_br: begin
                ctrl.branch = 1'b1;
                alu_op      = rv32i_pkg::alu_op_t'(funct3);  // compare code
                alu_or_cmp  = 1'b0;
            end
            rv32i_pkg::op_b_load: begin
                ctrl.regf_we  = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.alu_src  = 1'b1;
            end
            rv32i_pkg::op_b_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            rv32i_pkg::op_b_imm, rv32i_pkg::op_b_reg: begin
                ctrl.regf_we = 1'b1;
                ctrl.alu_src = (opcode == rv32i_pkg::op_b_imm);
                case (funct3)
                    3'b010: begin  // slt
                        alu_op     = rv32i_pkg::alu_op_t'(rv32i_pkg::blt);
                        alu_or_cmp = 1'b0;
                    end
                    3'b011: begin  // sltu
                        alu_op     = rv32i_pkg::alu_op_t'(rv32i_pkg::bltu);
                        alu_or_cmp = 1'b0;
                    end
                    3'b101:
                        alu_op = inst[30] ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
                    3'b000:  // sub exists only in the register form
                        alu_op = (opcode == rv32i_pkg::op_b_reg && inst[30])
                                 ? rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
                    default:
                        alu_op = rv32i_pkg::alu_op_t'(funct3);
                endcase
            end
            default: ;  // csr and unknown opcodes leave control at zero
        endcase
    end

    always_comb begin
        id_ex_next.pc         = pc;
        id_ex_next.rs1_s      = rs1_s;
        id_ex_next.rs2_s      = rs2_s;
        id_ex_next.rd_s       = rd_s;
        id_ex_next.rs1_v      = rs1_v;
        id_ex_next.rs2_v      = rs2_v;
        id_ex_next.imm        = imm;
        id_ex_next.alu_op     = alu_op;
        id_ex_next.alu_or_cmp = alu_or_cmp;
        id_ex_next.ctrl       = ctrl;
    end

    pipeline_regfile i_pipeline_regfile (
        .clk   (clk),
        .wb    (rf_wb),
        .rs1_s (rs1_s),
        .rs2_s (rs2_s),
        .rs1_v (rs1_v),
        .rs2_v (rs2_v)
    );

endmodule

//--- design/clear_counter.sv
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module clear_counter (
    input  logic                clk,
    input  logic                reset,
    input  logic                en,
    output rv32i_pkg::reg_sel_t index,
    output logic                last
);

    logic [`RV_CLR_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset)
            count <= '0;
        else if (en)
            count <= count + 1'b1;  // wraps back to 0 after the sweep
    end

    assign index = count;
    assign last  = (count == `RV_NUM_REGS - 1);

endmodule

//--- design/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                inst_valid,
    input  logic                ex_stall,
    input  rv32i_pkg::reg_sel_t rs1_s,
    input  rv32i_pkg::reg_sel_t rs2_s,
    input  rv32i_pkg::id_ex_t   ex_entry,
    input  logic                ex_valid,
    input  logic                clear_last,
    output logic                clearing,
    output logic                inst_taken,
    output logic                load_en,
    output logic                load_valid
);

    rv32i_pkg::issue_state_t state, state_next;
    logic                    hazard;

    // load in execute whose result the decoded instruction needs
    assign hazard = ex_valid && ex_entry.ctrl.mem_read && (ex_entry.rd_s != '0)
                    && (ex_entry.rd_s == rs1_s || ex_entry.rd_s == rs2_s);

    always_ff @(posedge clk) begin
        if (reset)
            state <= rv32i_pkg::st_clear;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        inst_taken = 1'b0;
        case (state)
            rv32i_pkg::st_clear: begin
                if (clear_last) state_next = rv32i_pkg::st_run;
            end
            rv32i_pkg::st_run: begin
                if (inst_valid && !ex_stall) begin
                    if (hazard)
                        state_next = rv32i_pkg::st_bubble;
                    else
                        inst_taken = 1'b1;
                end
            end
            rv32i_pkg::st_bubble: begin
                // register holds the bubble now, so the waiting instruction can go
                if (!ex_stall) begin
                    inst_taken = inst_valid;
                    state_next = rv32i_pkg::st_run;
                end
            end
            default: state_next = rv32i_pkg::st_clear;
        endcase
    end

    assign clearing   = (state == rv32i_pkg::st_clear);
    assign load_en    = !ex_stall;   // bubble whenever nothing is taken
    assign load_valid = inst_taken;

endmodule

//--- design/id_ex_register.sv
`timescale 1ns/1ps

module id_ex_register (
    input  logic              clk,
    input  logic              reset,
    input  logic              load_en,
    input  logic              load_valid,
    input  rv32i_pkg::id_ex_t d,
    output rv32i_pkg::id_ex_t q,
    output logic              valid
);

    always_ff @(posedge clk) begin
        if (reset)
            valid <= 1'b0;
        else if (load_en)
            valid <= load_valid;
    end

    // payload follows the enable, meaningful only with valid
    always_ff @(posedge clk) begin
        if (load_en) begin
            q <= d;
        end
    end

endmodule

//--- design/decode_top.sv
`timescale 1ns/1ps

module decode_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 inst_valid,
    input  rv32i_pkg::word_t     inst,
    input  rv32i_pkg::word_t     pc,
    input  logic                 ex_stall,
    input  logic                 wb_we,
    input  logic                 wb_valid,
    input  rv32i_pkg::reg_sel_t  wb_rd_s,
    input  rv32i_pkg::word_t     wb_rd_v,
    output logic                 inst_taken,
    output logic                 id_ex_valid,
    output rv32i_pkg::word_t     id_ex_pc,
    output rv32i_pkg::word_t     id_ex_rs1_v,
    output rv32i_pkg::word_t     id_ex_rs2_v,
    output rv32i_pkg::word_t     id_ex_imm,
    output rv32i_pkg::reg_sel_t  id_ex_rd_s,
    output rv32i_pkg::alu_op_t   id_ex_alu_op,
    output logic                 id_ex_alu_or_cmp,
    output rv32i_pkg::ctrl_t     id_ex_ctrl
);

    rv32i_pkg::id_ex_t   id_ex_next, id_ex_q;
    rv32i_pkg::reg_sel_t rs1_s, rs2_s, clear_index;
    logic                clearing, clear_last, load_en, load_valid;

    wb_if wb ();

    // counter zeroes the file through the write port while clearing
    always_comb begin
        if (clearing) begin
            wb.we    = 1'b1;
            wb.valid = 1'b1;
            wb.rd_s  = clear_index;
            wb.rd_v  = '0;
        end else begin
            wb.we    = wb_we;
            wb.valid = wb_valid;
            wb.rd_s  = wb_rd_s;
            wb.rd_v  = wb_rd_v;
        end
    end

    id_stage i_id_stage (
        .clk        (clk),
        .reset      (reset),
        .inst       (inst),
        .pc         (pc),
        .wb         (wb),
        .id_ex_next (id_ex_next),
        .rs1_s      (rs1_s),
        .rs2_s      (rs2_s)
    );

    clear_counter i_clear_counter (
        .clk   (clk),
        .reset (reset),
        .en    (clearing),
        .index (clear_index),
        .last  (clear_last)
    );

    issue_ctrl i_issue_ctrl (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .ex_stall   (ex_stall),
        .rs1_s      (rs1_s),
        .rs2_s      (rs2_s),
        .ex_entry   (id_ex_q),
        .ex_valid   (id_ex_valid),
        .clear_last (clear_last),
        .clearing   (clearing),
        .inst_taken (inst_taken),
        .load_en    (load_en),
        .load_valid (load_valid)
    );

    id_ex_register i_id_ex_register (
        .clk        (clk),
        .reset      (reset),
        .load_en    (load_en),
        .load_valid (load_valid),
        .d          (id_ex_next),
        .q          (id_ex_q),
        .valid      (id_ex_valid)
    );

    assign id_ex_pc         = id_ex_q.pc;
    assign id_ex_rs1_v      = id_ex_q.rs1_v;
    assign id_ex_rs2_v      = id_ex_q.rs2_v;
    assign id_ex_imm        = id_ex_q.imm;
    assign id_ex_rd_s       = id_ex_q.rd_s;
    assign id_ex_alu_op     = id_ex_q.alu_op;
    assign id_ex_alu_or_cmp = id_ex_q.alu_or_cmp;
    assign id_ex_ctrl       = id_ex_q.ctrl;

endmodule

//--- verification/decode_checker.sv
`timescale 1ns/1ps

module decode_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic        ex_stall,
    input  logic        wb_we,
    input  logic        wb_valid,
    input  logic [4:0]  wb_rd_s,
    input  logic [31:0] wb_rd_v,
    input  logic        inst_taken,
    input  logic        id_ex_valid,
    input  logic [31:0] id_ex_pc,
    input  logic [31:0] id_ex_rs1_v,
    input  logic [31:0] id_ex_rs2_v,
    input  logic [31:0] id_ex_imm,
    input  logic [4:0]  id_ex_rd_s,
    input  logic [2:0]  id_ex_alu_op,
    input  logic        id_ex_alu_or_cmp,
    input  logic [6:0]  id_ex_ctrl,
    output int          error_count,
    output int          check_count,
    output int          pending
);

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1_v;
        logic [31:0] rs2_v;
        logic [31:0] imm;
        logic [4:0]  rd_s;
        logic [2:0]  alu_op;
        logic        alu_or_cmp;
        logic [6:0]  ctrl;  // regf_we mem_read mem_write branch jal jalr alu_src
    } exp_t;

    logic [31:0] mregs [32];
    exp_t        exp_q [$];
    int          errs     = 0;
    int          checks   = 0;
    int          pend     = 0;
    int          clr_cnt  = 0;
    logic        m_valid  = 1'b0;
    logic        m_bubble = 1'b0;
    logic        m_mem_read;
    logic [4:0]  m_rd;

    assign error_count = errs;
    assign check_count = checks;
    assign pending     = pend;

    function automatic logic [31:0] read_model(input logic [4:0] sel);
        if (sel == '0)
            return '0;
        if (wb_we && wb_valid && wb_rd_s == sel)  // write in the same cycle wins
            return wb_rd_v;
        return mregs[sel];
    endfunction

    function automatic void build_expected(input logic [31:0] w, input logic [31:0] at_pc,
                                           output exp_t e, output logic [4:0] s1,
                                           output logic [4:0] s2);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] i_imm;
        opc = w[6:0];
        f3  = w[14:12];
        s1  = w[19:15];
        s2  = w[24:20];
        rd  = w[11:7];
        i_imm = {{21{w[31]}}, w[30:20]};
        e.pc         = at_pc;
        e.imm        = '0;
        e.alu_op     = rv32i_pkg::alu_add;
        e.alu_or_cmp = 1'b1;
        e.ctrl       = '0;
        case (opc)
            rv32i_pkg::op_b_lui, rv32i_pkg::op_b_auipc: begin
                s1     = '0;
                s2     = '0;
                e.imm  = {w[31:12], 12'h000};
                e.ctrl = 7'b1000001;
            end
            rv32i_pkg::op_b_jal: begin
                s1     = '0;
                s2     = '0;
                e.imm  = 32'd4;
                e.ctrl = 7'b1000101;
            end
            rv32i_pkg::op_b_jalr: begin
                s2     = '0;
                e.imm  = 32'd4;
                e.ctrl = 7'b1000011;
            end
            rv32i_pkg::op_b_br: begin
                rd           = '0;
                e.imm        = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                e.ctrl       = 7'b0001000;
                e.alu_op     = f3;
                e.alu_or_cmp = 1'b0;
            end
            rv32i_pkg::op_b_load: begin
                s2     = '0;
                e.imm  = i_imm;
                e.ctrl = 7'b1100001;
            end
            rv32i_pkg::op_b_store: begin
                rd     = '0;
                e.imm  = {{21{w[31]}}, w[30:25], w[11:7]};
                e.ctrl = 7'b0010001;
            end
            rv32i_pkg::op_b_imm, rv32i_pkg::op_b_reg: begin
                if (opc == rv32i_pkg::op_b_imm) begin
                    s2     = '0;
                    e.imm  = (f3 == 3'b101) ? {{27{w[31]}}, w[24:20]} : i_imm;
                    e.ctrl = 7'b1000001;
                end else begin
                    e.ctrl = 7'b1000000;
                end
                case (f3)
                    3'b010: begin
                        e.alu_op     = rv32i_pkg::blt;
                        e.alu_or_cmp = 1'b0;
                    end
                    3'b011: begin
                        e.alu_op     = rv32i_pkg::bltu;
                        e.alu_or_cmp = 1'b0;
                    end
                    3'b101:
                        e.alu_op = w[30] ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
                    3'b000:
                        e.alu_op = (opc == rv32i_pkg::op_b_reg && w[30])
                                   ? rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
                    default:
                        e.alu_op = f3;
                endcase
            end
            rv32i_pkg::op_b_csr: e.imm = i_imm;
            default: ;
        endcase
        e.rd_s  = rd;
        e.rs1_v = read_model(s1);
        e.rs2_v = read_model(s2);
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errs++;
            $display("[ERROR] %s expected 0x%h got 0x%h", name, exp_v, act_v);
        end
    endtask

    task automatic compare_entry(input exp_t x);
        check_field("id_ex_pc", x.pc, id_ex_pc);
        check_field("id_ex_rs1_v", x.rs1_v, id_ex_rs1_v);
        check_field("id_ex_rs2_v", x.rs2_v, id_ex_rs2_v);
        check_field("id_ex_imm", x.imm, id_ex_imm);
        check_field("id_ex_rd_s", 32'(x.rd_s), 32'(id_ex_rd_s));
        check_field("id_ex_alu_op", 32'(x.alu_op), 32'(id_ex_alu_op));
        check_field("id_ex_alu_or_cmp", 32'(x.alu_or_cmp), 32'(id_ex_alu_or_cmp));
        check_field("id_ex_ctrl", 32'(x.ctrl), 32'(id_ex_ctrl));
    endtask

    always @(posedge clk) begin
        exp_t       e;
        logic [4:0] s1;
        logic [4:0] s2;
        logic       hazard;
        logic       exp_taken;
        if (reset) begin
            clr_cnt  = 0;
            m_valid  = 1'b0;
            m_bubble = 1'b0;
            exp_q.delete();
            for (int i = 0; i < 32; i++)
                mregs[i] = '0;
        end else if (clr_cnt < 32) begin
            // sweep cycles, write-backs are overridden by the clear
            clr_cnt++;
            check_field("inst_taken", 32'h0, 32'(inst_taken));
            check_field("id_ex_valid", 32'h0, 32'(id_ex_valid));
        end else begin
            build_expected(inst, pc, e, s1, s2);
            hazard = m_valid && m_mem_read && m_rd != '0 && (m_rd == s1 || m_rd == s2);
            if (m_bubble)
                exp_taken = inst_valid && !ex_stall;
            else
                exp_taken = inst_valid && !ex_stall && !hazard;
            check_field("inst_taken", 32'(exp_taken), 32'(inst_taken));
            check_field("id_ex_valid", 32'(m_valid), 32'(id_ex_valid));

            if (id_ex_valid) begin
                if (exp_q.size() == 0) begin
                    errs++;
                    $display("id_ex_valid is high but no accepted instruction is waiting");
                end else begin
                    compare_entry(exp_q[0]);  // held entries are checked every stalled cycle
                    if (!ex_stall)
                        void'(exp_q.pop_front());
                end
            end

            if (!ex_stall) begin
                m_bubble = !m_bubble && inst_valid && hazard;
                m_valid  = exp_taken;
                if (exp_taken) begin
                    m_mem_read = e.ctrl[5];
                    m_rd       = e.rd_s;
                    exp_q.push_back(e);
                end
            end

            if (wb_we && wb_valid && wb_rd_s != '0)
                mregs[wb_rd_s] = wb_rd_v;
        end
        pend = exp_q.size();
    end

endmodule

//--- verification/tb_decode_top.sv
`timescale 1ns/1ps

module tb_decode_top;

    logic        clk;
    logic        reset       = 1'b1;
    logic        issuing     = 1'b0;
    logic        run_error   = 1'b0;
    logic        inst_valid  = 1'b0;
    logic [31:0] inst        = '0;
    logic [31:0] pc          = 32'h0000_1000;
    logic        ex_stall    = 1'b0;
    logic        wb_we       = 1'b0;
    logic        wb_valid    = 1'b0;
    logic [4:0]  wb_rd_s     = '0;
    logic [31:0] wb_rd_v     = '0;
    logic [31:0] lfsr        = 32'd46;
    int          taken_count = 0;

    logic        inst_taken, id_ex_valid, id_ex_alu_or_cmp;
    logic [31:0] id_ex_pc, id_ex_rs1_v, id_ex_rs2_v, id_ex_imm;
    logic [4:0]  id_ex_rd_s;
    logic [2:0]  id_ex_alu_op;
    logic [6:0]  id_ex_ctrl;
    int          error_count, check_count, pending;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [6:0] opcode_for(input logic [3:0] k);
        case (k)
            4'd0:    return rv32i_pkg::op_b_lui;
            4'd1:    return rv32i_pkg::op_b_auipc;
            4'd2:    return rv32i_pkg::op_b_jal;
            4'd3:    return rv32i_pkg::op_b_jalr;
            4'd4:    return rv32i_pkg::op_b_br;
            4'd5:    return rv32i_pkg::op_b_load;
            4'd6:    return rv32i_pkg::op_b_store;
            4'd7:    return rv32i_pkg::op_b_imm;
            4'd8:    return rv32i_pkg::op_b_reg;
            4'd9:    return rv32i_pkg::op_b_csr;
            default: return 7'b0001111;  // fence, not decoded
        endcase
    endfunction

    function automatic logic [31:0] build_inst();
        logic [31:0] w;
        logic [3:0]  k;
        w      = take_bits(32);
        k      = 4'(take_bits(4) % 11);
        w[6:0] = opcode_for(k);
        // half the time crowd the selects into x0..x3 so loads and write-backs collide
        if (take_bits(1) != '0) begin
            w[11:7]  = 5'(take_bits(2));
            w[19:15] = 5'(take_bits(2));
            w[24:20] = 5'(take_bits(2));
        end
        return w;
    endfunction

    always @(posedge clk) begin
        if (issuing) begin
            if (inst_taken)
                taken_count <= taken_count + 1;
            if (!inst_valid || inst_taken) begin  // queue holds an instruction until taken
                inst       <= build_inst();
                pc         <= pc + 32'd4;
                inst_valid <= take_bits(2) != '0;
            end
            ex_stall <= take_bits(3) == '0;
            wb_we    <= take_bits(1) != '0;
            wb_valid <= take_bits(2) != '0;
            wb_rd_s  <= (take_bits(1) != '0) ? 5'(take_bits(2)) : 5'(take_bits(5));
            wb_rd_v  <= take_bits(32);
        end else begin
            inst_valid <= 1'b0;
            ex_stall   <= 1'b0;
            wb_we      <= 1'b0;
        end
    end

    decode_top i_decode_top (
        .clk              (clk),
        .reset            (reset),
        .inst_valid       (inst_valid),
        .inst             (inst),
        .pc               (pc),
        .ex_stall         (ex_stall),
        .wb_we            (wb_we),
        .wb_valid         (wb_valid),
        .wb_rd_s          (wb_rd_s),
        .wb_rd_v          (wb_rd_v),
        .inst_taken       (inst_taken),
        .id_ex_valid      (id_ex_valid),
        .id_ex_pc         (id_ex_pc),
        .id_ex_rs1_v      (id_ex_rs1_v),
        .id_ex_rs2_v      (id_ex_rs2_v),
        .id_ex_imm        (id_ex_imm),
        .id_ex_rd_s       (id_ex_rd_s),
        .id_ex_alu_op     (id_ex_alu_op),
        .id_ex_alu_or_cmp (id_ex_alu_or_cmp),
        .id_ex_ctrl       (id_ex_ctrl)
    );

    decode_checker i_decode_checker (
        .clk              (clk),
        .reset            (reset),
        .inst_valid       (inst_valid),
        .inst             (inst),
        .pc               (pc),
        .ex_stall         (ex_stall),
        .wb_we            (wb_we),
        .wb_valid         (wb_valid),
        .wb_rd_s          (wb_rd_s),
        .wb_rd_v          (wb_rd_v),
        .inst_taken       (inst_taken),
        .id_ex_valid      (id_ex_valid),
        .id_ex_pc         (id_ex_pc),
        .id_ex_rs1_v      (id_ex_rs1_v),
        .id_ex_rs2_v      (id_ex_rs2_v),
        .id_ex_imm        (id_ex_imm),
        .id_ex_rd_s       (id_ex_rd_s),
        .id_ex_alu_op     (id_ex_alu_op),
        .id_ex_alu_or_cmp (id_ex_alu_or_cmp),
        .id_ex_ctrl       (id_ex_ctrl),
        .error_count      (error_count),
        .check_count      (check_count),
        .pending          (pending)
    );

    task automatic release_reset();
        repeat (8) @(posedge clk);
        reset   <= 1'b0;
        issuing <= 1'b1;
    endtask

    task automatic run_until(input int target);
        int cycles;
        cycles = 0;
        while (taken_count < target && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        if (taken_count < target) begin
            $display("only %0d instructions accepted before the timeout", taken_count);
            run_error = 1'b1;
        end
    endtask

    task automatic drain();
        int cycles;
        issuing <= 1'b0;
        cycles = 0;
        @(posedge clk);
        while ((inst_valid || id_ex_valid) && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
        if (inst_valid || id_ex_valid) begin
            $display("pipeline register did not drain after the stimulus stopped");
            run_error = 1'b1;
        end else if (pending != 0) begin
            $display("%0d accepted instructions never reached the outputs", pending);
            run_error = 1'b1;
        end
    endtask

    initial begin
        release_reset();
        run_until(1000);
        if (!run_error)
            drain();
        if (!run_error) begin
            // second sweep has to zero the values written so far
            @(posedge clk);
            reset <= 1'b1;
            release_reset();
            run_until(2000);
        end
        if (!run_error)
            drain();

        @(negedge clk);
        $display("accepted %0d checks %0d errors %0d", taken_count, check_count, error_count);
        if (error_count == 0 && !run_error)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
design/rv32i_pkg.sv
design/wb_if.sv
design/pipeline_regfile.sv
design/id_stage.sv
design/clear_counter.sv
design/issue_ctrl.sv
design/id_ex_register.sv
design/decode_top.sv
verification/decode_checker.sv
verification/tb_decode_top.sv

//--- run.sh
#!/bin/sh
# build the decode stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f sources.f --top-module tb_decode_top -o sim_decode
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1
